/* common/gsu_macros.svh */
`ifndef GSU_MACROS_SVH
`define GSU_MACROS_SVH

// ----------------------------------------
// Register file geometry
// ----------------------------------------
`define GSU_NUM_GPR      16

// GPRs sit below this offset, bits 4:1 pick the register
// Even offset is the low byte, odd the high byte
`define GSU_GPR_LIMIT    8'h20

// ----------------------------------------
// Special register offsets
// ----------------------------------------
`define GSU_ADDR_SFR     8'h30
`define GSU_ADDR_BRAMR   8'h33
`define GSU_ADDR_PBR     8'h34
`define GSU_ADDR_ROMBR   8'h35
`define GSU_ADDR_CFGR    8'h37
`define GSU_ADDR_SCBR    8'h38
`define GSU_ADDR_CLSR    8'h39
`define GSU_ADDR_SCMR    8'h3A
`define GSU_ADDR_VCR     8'h3B
`define GSU_ADDR_RAMBR   8'h3C
`define GSU_ADDR_CBR     8'h3E

// Version code after reset
`define GSU_VCR_RESET    8'd4

// GO flag position in SFR
`define GSU_SFR_GO_BIT   5

// ----------------------------------------
// Config port and cache
// ----------------------------------------
`define GSU_CFG_GROUP    8'd3
`define GSU_CFG_REGS     2
`define GSU_CACHE_DEPTH  512

`endif

/* common/gsu_pkg.sv */
`default_nettype none

// ----------------------------------------
// Shared vector types for the GSU host side
// ----------------------------------------
package gsu_pkg;

  // MMIO data byte, special registers, config values
  typedef logic [7:0] byte_t;

  // General registers and the 16-bit special registers
  typedef logic [15:0] word_t;

  // Full host address as seen on the cart bus
  typedef logic [23:0] snes_addr_t;

  // Debug read-back address
  // 0x000-0x0FF register state, 0x100-0x2FF cache
  typedef logic [9:0] dbg_addr_t;

  // Cache byte address, 512 entries
  typedef logic [8:0] cache_addr_t;

  // R0..R15 index
  typedef logic [3:0] gpr_idx_t;

endpackage

`default_nettype wire

/* common/gsu_cache_if.sv */
`default_nettype none

// One port of the instruction cache RAM
interface gsu_cache_if;
  import gsu_pkg::*;

  logic        we;
  cache_addr_t addr;
  byte_t       wrdata;
  byte_t       rddata;

  // Requester side, MMIO or debug
  modport host (
    output we,
    output addr,
    output wrdata,
    input  rddata
  );

  // Memory side
  modport ram (
    input  we,
    input  addr,
    input  wrdata,
    output rddata
  );

endinterface

`default_nettype wire

/* common/gsu_state_if.sv */
`default_nettype none

`include "gsu_macros.svh"

// Architectural register state, register file to debug view
interface gsu_state_if;
  import gsu_pkg::*;

  word_t gpr [`GSU_NUM_GPR];

  // Special registers
  word_t sfr;
  byte_t bramr;
  byte_t pbr;
  byte_t rombr;
  byte_t cfgr;
  byte_t scbr;
  byte_t clsr;
  byte_t scmr;
  byte_t vcr;
  byte_t rambr;
  word_t cbr;

  modport src (
    output gpr, sfr, bramr, pbr, rombr, cfgr,
    output scbr, clsr, scmr, vcr, rambr, cbr
  );

  modport view (
    input gpr, sfr, bramr, pbr, rombr, cfgr,
    input scbr, clsr, scmr, vcr, rambr, cbr
  );

endinterface

`default_nettype wire

/* mmio/gsu_mmio_regs.sv */
`default_nettype none

`include "gsu_macros.svh"

module gsu_mmio_regs (
  input  wire                      CLK,
  input  wire                      RST,
  input  wire                      ENABLE,
  input  wire                      SNES_RD_start,
  input  wire                      SNES_WR_end,
  input  wire gsu_pkg::snes_addr_t snes_addr,
  input  wire gsu_pkg::byte_t      data_in,
  output logic                     data_enable,
  output gsu_pkg::byte_t           data_out,
  gsu_cache_if.host                cache,
  gsu_state_if.src                 state
);
  import gsu_pkg::*;

  // ----------------------------------------
  // Input capture
  // ----------------------------------------
  byte_t      data_in_r;
  snes_addr_t addr_in_r;

  always_ff @(posedge CLK) begin
    data_in_r <= data_in;
    addr_in_r <= snes_addr;
  end

  // ----------------------------------------
  // Register state
  // ----------------------------------------
  word_t gpr [`GSU_NUM_GPR];
  byte_t gpr_lo_r;   // low byte waits here for the high-byte write
  word_t sfr;
  byte_t bramr;
  byte_t pbr;
  byte_t rombr;
  byte_t cfgr;
  byte_t scbr;
  byte_t clsr;
  byte_t scmr;
  byte_t vcr;
  byte_t rambr;
  word_t cbr;

  // Cache MMIO port
  logic        cache_we_r;
  logic        cache_rd_r;
  cache_addr_t cache_addr_r;
  byte_t       cache_wrdata_r;

  logic     sfr_go;
  byte_t    off;
  gpr_idx_t idx;
  logic     reg_region;
  logic     cache_region;
  logic     rd_hit;
  byte_t    rd_byte;
  logic     rd_ok;
  logic     wr_ok;
  logic     cache_ok;

  assign sfr_go = sfr[`GSU_SFR_GO_BIT];
  assign off    = addr_in_r[7:0];
  assign idx    = addr_in_r[4:1];

  // 0x000-0x0FF registers, 0x100-0x2FF cache window
  assign reg_region   = (addr_in_r[9:8] == 2'b00);
  assign cache_region = (addr_in_r[9:8] == 2'b01) || (addr_in_r[9:8] == 2'b10);

  // ----------------------------------------
  // Host read mux
  // ----------------------------------------
  always_comb begin
    rd_hit  = 1'b1;
    rd_byte = '0;
    if (off < `GSU_GPR_LIMIT) begin
      rd_byte = off[0] ? gpr[idx][15:8] : gpr[idx][7:0];
    end else begin
      case (off)
        `GSU_ADDR_SFR:         rd_byte = sfr[7:0];
        `GSU_ADDR_SFR + 8'd1:  rd_byte = sfr[15:8];
        `GSU_ADDR_PBR:         rd_byte = pbr;
        `GSU_ADDR_ROMBR:       rd_byte = rombr;
        `GSU_ADDR_VCR:         rd_byte = vcr;
        `GSU_ADDR_RAMBR:       rd_byte = rambr;
        `GSU_ADDR_CBR:         rd_byte = cbr[7:0];
        `GSU_ADDR_CBR + 8'd1:  rd_byte = cbr[15:8];
        // BRAMR, CFGR, SCBR, CLSR, SCMR are write-only to the host
        default:               rd_hit  = 1'b0;
      endcase
    end
  end

  // While GO runs only SFR/VCR read and SFR/SCMR write
  assign rd_ok = reg_region && rd_hit &&
                 (!sfr_go || off inside {`GSU_ADDR_SFR, `GSU_ADDR_SFR + 8'd1, `GSU_ADDR_VCR});
  assign wr_ok = reg_region &&
                 (!sfr_go || off inside {`GSU_ADDR_SFR, `GSU_ADDR_SFR + 8'd1, `GSU_ADDR_SCMR});
  assign cache_ok = cache_region && !sfr_go;

  // ----------------------------------------
  // Access sequencing
  // ----------------------------------------
  always_ff @(posedge CLK) begin
    if (RST) begin
      for (int i = 0; i < `GSU_NUM_GPR; i++) begin
        gpr[i] <= '0;
      end
      sfr         <= '0;
      bramr       <= '0;
      pbr         <= '0;
      rombr       <= '0;
      cfgr        <= '0;
      scbr        <= '0;
      clsr        <= '0;
      scmr        <= '0;
      vcr         <= `GSU_VCR_RESET;
      rambr       <= '0;
      cbr         <= '0;
      data_enable <= 1'b0;
      cache_we_r  <= 1'b0;
      cache_rd_r  <= 1'b0;
    end else if (!ENABLE) begin
      // Host released, cache byte is settled by now
      if (data_enable && cache_rd_r) begin
        data_out <= cache.rddata;
      end
      data_enable <= 1'b0;
      cache_we_r  <= 1'b0;
      cache_rd_r  <= 1'b0;
    end else if (SNES_WR_end) begin
      if (wr_ok) begin
        if (off < `GSU_GPR_LIMIT) begin
          // Odd offset commits the whole word
          if (off[0]) begin
            gpr[idx] <= {data_in_r, gpr_lo_r};
          end else begin
            gpr_lo_r <= data_in_r;
          end
        end else begin
          // Only the implemented bits take the write
          case (off)
            `GSU_ADDR_SFR:        sfr[6:1] <= data_in_r[6:1];
            `GSU_ADDR_SFR + 8'd1: {sfr[15], sfr[12:8]} <= {data_in_r[7], data_in_r[4:0]};
            `GSU_ADDR_BRAMR:      bramr[0] <= data_in_r[0];
            `GSU_ADDR_PBR:        pbr <= data_in_r;
            `GSU_ADDR_CFGR:       {cfgr[7], cfgr[5]} <= {data_in_r[7], data_in_r[5]};
            `GSU_ADDR_SCBR:       scbr <= data_in_r;
            `GSU_ADDR_CLSR:       clsr[0] <= data_in_r[0];
            `GSU_ADDR_SCMR:       scmr[5:0] <= data_in_r[5:0];
            default: ;
          endcase
        end
      end else if (cache_ok) begin
        cache_we_r     <= 1'b1;
        cache_wrdata_r <= data_in_r;
        cache_addr_r   <= {~addr_in_r[8], addr_in_r[7:0]};
      end
    end else if (SNES_RD_start) begin
      if (rd_ok) begin
        data_enable <= 1'b1;
        data_out    <= rd_byte;
      end else if (cache_ok) begin
        // Address goes out now, data lands on release
        data_enable  <= 1'b1;
        cache_rd_r   <= 1'b1;
        cache_addr_r <= {~addr_in_r[8], addr_in_r[7:0]};
      end
    end
  end

  // Write pulse straight from the sequencer
  assign cache.we     = cache_we_r;
  assign cache.addr   = cache_addr_r;
  assign cache.wrdata = cache_wrdata_r;

  // State to debug view
  assign state.gpr   = gpr;
  assign state.sfr   = sfr;
  assign state.bramr = bramr;
  assign state.pbr   = pbr;
  assign state.rombr = rombr;
  assign state.cfgr  = cfgr;
  assign state.scbr  = scbr;
  assign state.clsr  = clsr;
  assign state.scmr  = scmr;
  assign state.vcr   = vcr;
  assign state.rambr = rambr;
  assign state.cbr   = cbr;

endmodule

`default_nettype wire

/* rtl/gsu_cache_ram.sv */
`default_nettype none

`include "gsu_macros.svh"

module gsu_cache_ram (
  input wire       CLK,
  gsu_cache_if.ram port_a,
  gsu_cache_if.ram port_b
);
  import gsu_pkg::*;

  byte_t mem [`GSU_CACHE_DEPTH];

  // ----------------------------------------
  // Port A, host MMIO
  // ----------------------------------------
  always @(posedge CLK) begin
    if (port_a.we) begin
      mem[port_a.addr] <= port_a.wrdata;
    end
    // Read old data on a same-address write
    port_a.rddata <= mem[port_a.addr];
  end

  // ----------------------------------------
  // Port B, debug read-back
  // ----------------------------------------
  always @(posedge CLK) begin
    if (port_b.we) begin
      mem[port_b.addr] <= port_b.wrdata;
    end
    port_b.rddata <= mem[port_b.addr];
  end

endmodule

`default_nettype wire

/* rtl/gsu_config_regs.sv */
`default_nettype none

`include "gsu_macros.svh"

module gsu_config_regs (
  input  wire                 CLK,
  input  wire                 RST,
  input  wire gsu_pkg::byte_t group,
  input  wire gsu_pkg::byte_t index,
  input  wire gsu_pkg::byte_t value,
  input  wire gsu_pkg::byte_t invmask,
  input  wire                 we,
  input  wire gsu_pkg::byte_t read_index,
  output gsu_pkg::byte_t      data_out
);
  import gsu_pkg::*;

  localparam int cfg_idx_w = $clog2(`GSU_CFG_REGS);

  byte_t cfg [`GSU_CFG_REGS];
  logic  wr_hit;

  assign wr_hit = we && (group == `GSU_CFG_GROUP) && (index < `GSU_CFG_REGS);

  // Mask bit set keeps the old bit
  always_ff @(posedge CLK) begin
    if (RST) begin
      for (int i = 0; i < `GSU_CFG_REGS; i++) begin
        cfg[i] <= '0;
      end
    end else if (wr_hit) begin
      cfg[index[cfg_idx_w-1:0]] <= (cfg[index[cfg_idx_w-1:0]] & invmask) |
                                   (value & ~invmask);
    end
  end

  // Out of range reads back zero
  assign data_out = (read_index < `GSU_CFG_REGS) ? cfg[read_index[cfg_idx_w-1:0]] : '0;

endmodule

`default_nettype wire

/* rtl/gsu_debug_view.sv */
`default_nettype none

`include "gsu_macros.svh"

module gsu_debug_view (
  input  wire gsu_pkg::dbg_addr_t pgm_addr,
  output gsu_pkg::byte_t          pgm_data,
  gsu_cache_if.host               cache,
  gsu_state_if.view               state
);
  import gsu_pkg::*;

  byte_t    off;
  gpr_idx_t idx;
  logic     cache_sel;

  assign off       = pgm_addr[7:0];
  assign idx       = pgm_addr[4:1];
  assign cache_sel = (pgm_addr[9:8] == 2'b01) || (pgm_addr[9:8] == 2'b10);

  // Read-only port into the cache
  assign cache.we     = 1'b0;
  assign cache.wrdata = '0;
  assign cache.addr   = {~pgm_addr[8], pgm_addr[7:0]};

  // ----------------------------------------
  // Offset decode
  // ----------------------------------------
  always_comb begin
    pgm_data = '0;
    if (cache_sel) begin
      // One cycle behind the address
      pgm_data = cache.rddata;
    end else if (pgm_addr[9:8] == 2'b00) begin
      if (off < `GSU_GPR_LIMIT) begin
        pgm_data = off[0] ? state.gpr[idx][15:8] : state.gpr[idx][7:0];
      end else begin
        // Full width, host-hidden registers too
        case (off)
          `GSU_ADDR_SFR:        pgm_data = state.sfr[7:0];
          `GSU_ADDR_SFR + 8'd1: pgm_data = state.sfr[15:8];
          `GSU_ADDR_BRAMR:      pgm_data = state.bramr;
          `GSU_ADDR_PBR:        pgm_data = state.pbr;
          `GSU_ADDR_ROMBR:      pgm_data = state.rombr;
          `GSU_ADDR_CFGR:       pgm_data = state.cfgr;
          `GSU_ADDR_SCBR:       pgm_data = state.scbr;
          `GSU_ADDR_CLSR:       pgm_data = state.clsr;
          `GSU_ADDR_SCMR:       pgm_data = state.scmr;
          `GSU_ADDR_VCR:        pgm_data = state.vcr;
          `GSU_ADDR_RAMBR:      pgm_data = state.rambr;
          `GSU_ADDR_CBR:        pgm_data = state.cbr[7:0];
          `GSU_ADDR_CBR + 8'd1: pgm_data = state.cbr[15:8];
          // 0x40-0x47 pixel/ROM/RAM buffers not built, read zero
          default:              pgm_data = '0;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/gsu.sv */
`default_nettype none

module gsu (
  input  wire                      CLK,
  input  wire                      RST,

  // Host MMIO
  input  wire                      ENABLE,
  input  wire                      SNES_RD_start,
  input  wire                      SNES_WR_end,
  input  wire gsu_pkg::snes_addr_t SNES_ADDR,
  input  wire gsu_pkg::byte_t      DATA_IN,
  output wire                      DATA_ENABLE,
  output wire gsu_pkg::byte_t      DATA_OUT,

  // Debug read-back
  input  wire gsu_pkg::dbg_addr_t  PGM_ADDR,
  output wire gsu_pkg::byte_t      PGM_DATA,

  // Config port
  input  wire gsu_pkg::byte_t      reg_group_in,
  input  wire gsu_pkg::byte_t      reg_index_in,
  input  wire gsu_pkg::byte_t      reg_value_in,
  input  wire gsu_pkg::byte_t      reg_invmask_in,
  input  wire                      reg_we_in,
  input  wire gsu_pkg::byte_t      reg_read_in,
  output wire gsu_pkg::byte_t      config_data_out
);

  // Cache port A for MMIO, port B for debug
  gsu_cache_if mmio_cache ();
  gsu_cache_if dbg_cache ();
  gsu_state_if state ();

  gsu_mmio_regs i_mmio_regs (
    .CLK           (CLK),
    .RST           (RST),
    .ENABLE        (ENABLE),
    .SNES_RD_start (SNES_RD_start),
    .SNES_WR_end   (SNES_WR_end),
    .snes_addr     (SNES_ADDR),
    .data_in       (DATA_IN),
    .data_enable   (DATA_ENABLE),
    .data_out      (DATA_OUT),
    .cache         (mmio_cache.host),
    .state         (state.src)
  );

  gsu_cache_ram i_cache_ram (
    .CLK    (CLK),
    .port_a (mmio_cache.ram),
    .port_b (dbg_cache.ram)
  );

  gsu_config_regs i_config_regs (
    .CLK        (CLK),
    .RST        (RST),
    .group      (reg_group_in),
    .index      (reg_index_in),
    .value      (reg_value_in),
    .invmask    (reg_invmask_in),
    .we         (reg_we_in),
    .read_index (reg_read_in),
    .data_out   (config_data_out)
  );

  gsu_debug_view i_debug_view (
    .pgm_addr (PGM_ADDR),
    .pgm_data (PGM_DATA),
    .cache    (dbg_cache.host),
    .state    (state.view)
  );

endmodule

`default_nettype wire

/* tests/gsu_assert.sv */
`default_nettype none

`include "gsu_macros.svh"

// ----------------------------------------
// Host-side protocol checks on the top level
// ----------------------------------------
module gsu_assert (
  input wire CLK,
  input wire RST,
  input wire enable,
  input wire data_enable,
  input wire cache_we,
  input wire sfr_go
);

  // Read strobe starts low out of reset
  a_de_after_reset: assert property (
    @(posedge CLK) RST |=> !data_enable
  ) else $error("DATA_ENABLE high in the cycle after reset");

  // Host release drops the read strobe
  a_de_after_release: assert property (
    @(posedge CLK) !enable |=> !data_enable
  ) else $error("DATA_ENABLE high in the cycle after ENABLE low");

  // Cache locked while GO runs
  a_no_cache_we_in_go: assert property (
    @(posedge CLK) disable iff (RST) !(cache_we && sfr_go)
  ) else $error("Cache write enable high while GO is set");

endmodule

// MMIO cache port and GO flag taken from inside the top level
bind gsu gsu_assert i_gsu_assert (
  .CLK         (CLK),
  .RST         (RST),
  .enable      (ENABLE),
  .data_enable (DATA_ENABLE),
  .cache_we    (mmio_cache.we),
  .sfr_go      (state.sfr[`GSU_SFR_GO_BIT])
);

`default_nettype wire

/* tests/gsu_tb.sv */
`default_nettype none

`include "gsu_macros.svh"

module gsu_tb;
  import gsu_pkg::*;

  typedef enum logic [2:0] {op_host_wr, op_host_rd, op_cfg_wr, op_cfg_rd, op_dbg_rd} op_e;

  // One table row
  // exp bit 8 is the expected DATA_ENABLE on host reads
  // rsel 0 uses data/exp as given, 1..3 picks a random byte
  typedef struct packed {
    op_e         op;
    logic [9:0]  off;
    byte_t       grp;
    byte_t       data;
    byte_t       mask;
    logic [15:0] exp;
    logic [1:0]  rsel;
  } entry_t;

  localparam snes_addr_t host_base = 24'h003000;

  logic       CLK;
  logic       RST;
  logic       ENABLE;
  logic       SNES_RD_start;
  logic       SNES_WR_end;
  snes_addr_t SNES_ADDR;
  byte_t      DATA_IN;
  logic       DATA_ENABLE;
  byte_t      DATA_OUT;
  dbg_addr_t  PGM_ADDR;
  byte_t      PGM_DATA;
  byte_t      reg_group_in;
  byte_t      reg_index_in;
  byte_t      reg_value_in;
  byte_t      reg_invmask_in;
  logic       reg_we_in;
  byte_t      reg_read_in;
  byte_t      config_data_out;

  entry_t tests [$];
  string  names [$];
  byte_t  rnd [3];
  int     errors;
  int     checks;
  logic   table_ready;

  gsu i_dut (
    .CLK             (CLK),
    .RST             (RST),
    .ENABLE          (ENABLE),
    .SNES_RD_start   (SNES_RD_start),
    .SNES_WR_end     (SNES_WR_end),
    .SNES_ADDR       (SNES_ADDR),
    .DATA_IN         (DATA_IN),
    .DATA_ENABLE     (DATA_ENABLE),
    .DATA_OUT        (DATA_OUT),
    .PGM_ADDR        (PGM_ADDR),
    .PGM_DATA        (PGM_DATA),
    .reg_group_in    (reg_group_in),
    .reg_index_in    (reg_index_in),
    .reg_value_in    (reg_value_in),
    .reg_invmask_in  (reg_invmask_in),
    .reg_we_in       (reg_we_in),
    .reg_read_in     (reg_read_in),
    .config_data_out (config_data_out)
  );

  // 40-unit clock
  always #20 CLK = ~CLK;

  task check_value(input string name, input logic [15:0] exp, input logic [15:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // ----------------------------------------
  // Table building
  // ----------------------------------------
  task push_entry(input string name, input op_e op, input logic [9:0] off, input byte_t grp,
                  input byte_t data, input byte_t mask, input logic [15:0] exp,
                  input logic [1:0] rsel);
    tests.push_back('{op, off, grp, data, mask, exp, rsel});
    names.push_back(name);
  endtask

  task add_host_write(input string name, input logic [9:0] off, input byte_t data,
                      input logic [1:0] rsel);
    push_entry(name, op_host_wr, off, 8'h00, data, 8'h00, 16'h0000, rsel);
  endtask

  task add_host_read(input string name, input logic [9:0] off, input logic [15:0] exp,
                     input logic [1:0] rsel);
    push_entry(name, op_host_rd, off, 8'h00, 8'h00, 8'h00, exp, rsel);
  endtask

  task add_dbg_read(input string name, input logic [9:0] off, input byte_t exp,
                    input logic [1:0] rsel);
    push_entry(name, op_dbg_rd, off, 8'h00, 8'h00, 8'h00, {8'h00, exp}, rsel);
  endtask

  task add_cfg_write(input string name, input byte_t grp, input byte_t idx,
                     input byte_t value, input byte_t mask);
    push_entry(name, op_cfg_wr, {2'b00, idx}, grp, value, mask, 16'h0000, 2'd0);
  endtask

  task add_cfg_read(input string name, input byte_t idx, input byte_t exp);
    push_entry(name, op_cfg_rd, {2'b00, idx}, 8'h00, 8'h00, 8'h00, {8'h00, exp}, 2'd0);
  endtask

  // ----------------------------------------
  // Bus drivers
  // ----------------------------------------
  // Address/data one cycle ahead of the strobe, ENABLE held two cycles past it
  task host_access(input logic wr, input snes_addr_t addr, input byte_t data,
                   output logic de, output byte_t early, output byte_t late);
    @(posedge CLK);
    ENABLE    <= 1'b1;
    SNES_ADDR <= addr;
    DATA_IN   <= data;
    @(posedge CLK);
    if (wr) begin
      SNES_WR_end <= 1'b1;
    end else begin
      SNES_RD_start <= 1'b1;
    end
    @(posedge CLK);
    SNES_WR_end   <= 1'b0;
    SNES_RD_start <= 1'b0;
    @(negedge CLK);
    de    = DATA_ENABLE;
    early = DATA_OUT;
    @(posedge CLK);
    @(posedge CLK);
    ENABLE <= 1'b0;
    // Release edge, cache byte lands in DATA_OUT
    @(posedge CLK);
    @(negedge CLK);
    late = DATA_OUT;
  endtask

  task run_entry(input int i);
    entry_t      e;
    byte_t       data;
    logic [15:0] exp;
    logic        de;
    byte_t       early;
    byte_t       late;
    e    = tests[i];
    data = e.data;
    exp  = e.exp;
    if (e.rsel != 2'd0) begin
      data     = rnd[e.rsel - 1];
      exp[7:0] = rnd[e.rsel - 1];
    end
    case (e.op)
      op_host_wr, op_host_rd: begin
        host_access(e.op == op_host_wr, host_base | e.off, data, de, early, late);
        if (e.op == op_host_rd) begin
          if (!exp[8]) begin
            check_value(names[i], exp, {15'h0000, de});
          end else begin
            check_value(names[i], exp, {7'h00, de, (e.off[9:8] != 2'b00) ? late : early});
          end
        end
      end
      op_cfg_wr: begin
        @(posedge CLK);
        reg_group_in   <= e.grp;
        reg_index_in   <= e.off[7:0];
        reg_value_in   <= data;
        reg_invmask_in <= e.mask;
        reg_we_in      <= 1'b1;
        @(posedge CLK);
        reg_we_in <= 1'b0;
      end
      op_cfg_rd: begin
        @(posedge CLK);
        reg_read_in <= e.off[7:0];
        @(negedge CLK);
        check_value(names[i], exp, {8'h00, config_data_out});
      end
      default: begin
        // Cache bytes need the extra edge, registers are ready anyway
        @(posedge CLK);
        PGM_ADDR <= e.off;
        @(posedge CLK);
        @(negedge CLK);
        check_value(names[i], exp, {8'h00, PGM_DATA});
      end
    endcase
  endtask

  // ----------------------------------------
  // Stimulus table
  // ----------------------------------------
  task build_table();
    // Reset state through the debug port
    for (int o = 0; o < 8'h48; o++) begin
      add_dbg_read($sformatf("reset dbg %02h", o), o[9:0],
                   (o == `GSU_ADDR_VCR) ? `GSU_VCR_RESET : 8'h00, 2'd0);
    end
    add_host_read("reset host vcr", `GSU_ADDR_VCR, 16'h0104, 2'd0);
    add_host_read("reset host pbr", `GSU_ADDR_PBR, 16'h0100, 2'd0);

    // GPR words, low then high
    add_host_write("r1 lo", 10'h002, 8'h34, 2'd0);
    add_host_write("r1 hi", 10'h003, 8'h12, 2'd0);
    add_host_write("r15 lo", 10'h01E, 8'hEF, 2'd0);
    add_host_write("r15 hi", 10'h01F, 8'hBE, 2'd0);
    add_host_read("host r1 lo", 10'h002, 16'h0134, 2'd0);
    add_host_read("host r1 hi", 10'h003, 16'h0112, 2'd0);
    add_host_read("host r15 lo", 10'h01E, 16'h01EF, 2'd0);
    add_host_read("host r15 hi", 10'h01F, 16'h01BE, 2'd0);
    add_dbg_read("dbg r1 lo", 10'h002, 8'h34, 2'd0);
    add_dbg_read("dbg r1 hi", 10'h003, 8'h12, 2'd0);
    add_dbg_read("dbg r15 lo", 10'h01E, 8'hEF, 2'd0);
    add_dbg_read("dbg r15 hi", 10'h01F, 8'hBE, 2'd0);
    add_host_write("r2 lo only", 10'h004, 8'h77, 2'd0);
    add_dbg_read("r2 lo unchanged", 10'h004, 8'h00, 2'd0);
    add_dbg_read("r2 hi unchanged", 10'h005, 8'h00, 2'd0);

    // Writable bits only
    add_host_write("bramr ff", `GSU_ADDR_BRAMR, 8'hFF, 2'd0);
    add_host_write("cfgr ff", `GSU_ADDR_CFGR, 8'hFF, 2'd0);
    add_host_write("clsr ff", `GSU_ADDR_CLSR, 8'hFF, 2'd0);
    add_host_write("scmr ff", `GSU_ADDR_SCMR, 8'hFF, 2'd0);
    add_host_write("sfr hi ff", `GSU_ADDR_SFR + 1, 8'hFF, 2'd0);
    add_host_write("rombr ff", `GSU_ADDR_ROMBR, 8'hFF, 2'd0);
    add_host_write("pbr 5a", `GSU_ADDR_PBR, 8'h5A, 2'd0);
    add_dbg_read("bramr mask", `GSU_ADDR_BRAMR, 8'h01, 2'd0);
    add_dbg_read("cfgr mask", `GSU_ADDR_CFGR, 8'hA0, 2'd0);
    add_dbg_read("clsr mask", `GSU_ADDR_CLSR, 8'h01, 2'd0);
    add_dbg_read("scmr mask", `GSU_ADDR_SCMR, 8'h3F, 2'd0);
    add_dbg_read("sfr hi mask", `GSU_ADDR_SFR + 1, 8'h9F, 2'd0);
    add_dbg_read("rombr stays zero", `GSU_ADDR_ROMBR, 8'h00, 2'd0);
    add_host_read("host pbr", `GSU_ADDR_PBR, 16'h015A, 2'd0);

    // Cache window ends
    add_host_write("cache 100 wr", 10'h100, 8'h00, 2'd1);
    add_host_write("cache 2ff wr", 10'h2FF, 8'h00, 2'd2);
    add_host_read("host cache 100", 10'h100, 16'h0100, 2'd1);
    add_host_read("host cache 2ff", 10'h2FF, 16'h0100, 2'd2);
    add_dbg_read("dbg cache 100", 10'h100, 8'h00, 2'd1);
    add_dbg_read("dbg cache 2ff", 10'h2FF, 8'h00, 2'd2);

    // GO set, access restricted
    add_host_write("sfr go", `GSU_ADDR_SFR, 8'hFF, 2'd0);
    add_dbg_read("sfr lo mask", `GSU_ADDR_SFR, 8'h7E, 2'd0);
    add_host_read("go host sfr", `GSU_ADDR_SFR, 16'h017E, 2'd0);
    add_host_read("go host vcr", `GSU_ADDR_VCR, 16'h0104, 2'd0);
    add_host_write("go r3 lo", 10'h006, 8'h11, 2'd0);
    add_host_write("go r3 hi", 10'h007, 8'h22, 2'd0);
    add_dbg_read("go r3 lo ignored", 10'h006, 8'h00, 2'd0);
    add_dbg_read("go r3 hi ignored", 10'h007, 8'h00, 2'd0);
    add_host_read("go pbr no enable", `GSU_ADDR_PBR, 16'h0000, 2'd0);
    add_host_write("go scmr", `GSU_ADDR_SCMR, 8'h15, 2'd0);
    add_dbg_read("go scmr lands", `GSU_ADDR_SCMR, 8'h15, 2'd0);
    add_host_write("go cache wr", 10'h100, 8'h00, 2'd3);
    add_dbg_read("go cache unchanged", 10'h100, 8'h00, 2'd1);

    // Config group, old & mask | value & ~mask
    add_cfg_read("cfg0 reset", 8'd0, 8'h00);
    add_cfg_read("cfg1 reset", 8'd1, 8'h00);
    add_cfg_write("cfg0 a5", `GSU_CFG_GROUP, 8'd0, 8'hA5, 8'h00);
    add_cfg_read("cfg0 full", 8'd0, 8'hA5);
    add_cfg_write("cfg0 3c/f0", `GSU_CFG_GROUP, 8'd0, 8'h3C, 8'hF0);
    add_cfg_read("cfg0 masked", 8'd0, 8'hAC);
    add_cfg_write("cfg1 ff/0f", `GSU_CFG_GROUP, 8'd1, 8'hFF, 8'h0F);
    add_cfg_read("cfg1 masked", 8'd1, 8'hF0);
    add_cfg_write("cfg1 00/3c", `GSU_CFG_GROUP, 8'd1, 8'h00, 8'h3C);
    add_cfg_read("cfg1 masked again", 8'd1, 8'h30);
    add_cfg_write("cfg other group", 8'd2, 8'd0, 8'h00, 8'h00);
    add_cfg_write("cfg index 2", `GSU_CFG_GROUP, 8'd2, 8'h55, 8'h00);
    add_cfg_read("cfg0 untouched", 8'd0, 8'hAC);
    add_cfg_read("cfg1 untouched", 8'd1, 8'h30);
    add_cfg_read("cfg index 5", 8'd5, 8'h00);
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    int unsigned seed_val;
    CLK            = 1'b0;
    RST            = 1'b1;
    ENABLE         = 1'b0;
    SNES_RD_start  = 1'b0;
    SNES_WR_end    = 1'b0;
    SNES_ADDR      = '0;
    DATA_IN        = '0;
    PGM_ADDR       = '0;
    reg_group_in   = '0;
    reg_index_in   = '0;
    reg_value_in   = '0;
    reg_invmask_in = '0;
    reg_we_in      = 1'b0;
    reg_read_in    = '0;
    errors         = 0;
    checks         = 0;
    table_ready    = 1'b0;

    seed_val = $urandom(51);
    for (int i = 0; i < 3; i++) begin
      rnd[i] = $urandom;
    end
    // Both window ends hold different bytes so an address alias shows up
    if (rnd[1] == rnd[0]) begin
      rnd[1] = ~rnd[0];
    end
    // Ignored GO write must differ from the stored byte
    if (rnd[2] == rnd[0]) begin
      rnd[2] = ~rnd[0];
    end

    build_table();
    table_ready = 1'b1;

    repeat (2) @(posedge CLK);
    RST <= 1'b0;

    for (int i = 0; i < tests.size(); i++) begin
      run_entry(i);
    end

    repeat (2) @(posedge CLK);
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // Watchdog, ten cycles per table row plus margin
  initial begin
    longint limit;
    wait (table_ready);
    limit = longint'(tests.size()) * 10 * 40 + 4000;
    #(limit);
    $display("Timeout: run did not finish within %0d time units", limit);
    $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
+incdir+common
common/gsu_pkg.sv
common/gsu_cache_if.sv
common/gsu_state_if.sv
mmio/gsu_mmio_regs.sv
rtl/gsu_cache_ram.sv
rtl/gsu_config_regs.sv
rtl/gsu_debug_view.sv
rtl/gsu.sv
tests/gsu_assert.sv
tests/gsu_tb.sv
